// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_lsu_mem
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The simulator's exit status is not used, the log search decides
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+include
logic/lsu_mem_pkg.sv
logic/lsu_req_if.sv
logic/bank_if.sv
logic/lsu_port.sv
logic/bank_arbiter.sv
logic/bg_lsu_crossbar.sv
logic/bank_group.sv
logic/lsu_mem_top.sv
sim/clk_gen.sv
sim/tb_lsu_mem.sv

// ==== include/lsu_mem_cfg.svh ====
`ifndef LSU_MEM_CFG_SVH
`define LSU_MEM_CFG_SVH

// Load/store units sharing the memory
`define LSU_NUM     4

// Bank groups, selected by the low word address bits
`define BG_NUM      4

// Words per bank
`define BG_DEPTH    64

`define DATA_W      32

// Request queue entries per LSU, also the initial credit count
`define LSU_Q_DEPTH 4

`endif

// ==== logic/bank_arbiter.sv ====
`include "lsu_mem_cfg.svh"

module bank_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    lsu_req_if.arb               req [`LSU_NUM],
    output lsu_mem_pkg::bg_sel_t bank_sel [`BG_NUM],
    output logic                 bank_busy [`BG_NUM]
);

    localparam int BANK_BITS = $bits(lsu_mem_pkg::bg_sel_t);

    logic [`LSU_NUM-1:0]    head_valid;
    logic [`LSU_NUM-1:0]    grant;
    logic [`LSU_NUM-1:0]    waiting;
    lsu_mem_pkg::bg_sel_t   head_bg [`LSU_NUM];
    lsu_mem_pkg::rr_state_e rr_q    [`BG_NUM];

    for (genvar i = 0; i < `LSU_NUM; i++) begin : g_lsu
        assign head_valid[i]  = req[i].head_valid;
        assign head_bg[i]     = req[i].head_addr[BANK_BITS-1:0];
        assign req[i].grant   = grant[i];
    end

    // Walk backwards so the LSU right after the last winner is written last
    always_comb begin
        lsu_mem_pkg::bg_sel_t cand;
        for (int b = 0; b < `BG_NUM; b++) begin
            bank_sel[b]  = '0;
            bank_busy[b] = 1'b0;
            for (int k = `LSU_NUM; k >= 1; k--) begin
                cand = lsu_mem_pkg::bg_sel_t'((int'(rr_q[b]) + k) % `LSU_NUM);
                if (head_valid[cand] && head_bg[cand] == lsu_mem_pkg::bg_sel_t'(b)) begin
                    bank_sel[b]  = cand;
                    bank_busy[b] = 1'b1;
                end
            end
        end
    end

    // A head targets one bank only, so at most one bank grants each LSU
    always_comb begin
        grant = '0;
        for (int b = 0; b < `BG_NUM; b++) begin
            if (bank_busy[b]) begin
                grant[bank_sel[b]] = 1'b1;
            end
        end
    end

    assign waiting = head_valid & ~grant;

    always_ff @(posedge clk) begin
        for (int b = 0; b < `BG_NUM; b++) begin
            if (reset) begin
                rr_q[b] <= lsu_mem_pkg::LAST_L3;
            end else if (bank_busy[b]) begin
                rr_q[b] <= lsu_mem_pkg::rr_state_e'(bank_sel[b]);
            end
        end
    end

    // Round robin lets a waiting head lose at most three times in a row
    for (genvar i = 0; i < `LSU_NUM; i++) begin : g_chk
        a_no_starvation: assert property (@(posedge clk) disable iff (reset)
            !(waiting[i] && $past(waiting[i], 1) && $past(waiting[i], 2) &&
              $past(waiting[i], 3)));
    end

endmodule

// ==== logic/bank_group.sv ====
`include "lsu_mem_cfg.svh"

module bank_group (
    input  logic clk,
    input  logic reset,
    bank_if.bank bank
);

    lsu_mem_pkg::data_t   mem [`BG_DEPTH];
    lsu_mem_pkg::data_t   rdata_q;
    lsu_mem_pkg::bg_sel_t rsp_lsu_q;
    logic                 rsp_valid_q;
    logic                 rd_en;
    logic                 wr_en;

    assign rd_en = bank.en && !bank.write;
    assign wr_en = bank.en && bank.write;

    // Single port, one access per cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[bank.row] <= bank.wdata;
        end
        if (rd_en) begin
            rdata_q   <= mem[bank.row];
            rsp_lsu_q <= bank.lsu_id;
        end
    end

    // Writes are silent, only reads answer
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_en;
        end
    end

    assign bank.rsp_valid = rsp_valid_q;
    assign bank.rdata     = rdata_q;
    assign bank.rsp_lsu   = rsp_lsu_q;

endmodule

// ==== logic/bank_if.sv ====
interface bank_if;

    logic                 en;
    logic                 write;
    lsu_mem_pkg::row_t    row;
    lsu_mem_pkg::data_t   wdata;
    lsu_mem_pkg::bg_sel_t lsu_id;
    logic                 rsp_valid;
    lsu_mem_pkg::data_t   rdata;
    lsu_mem_pkg::bg_sel_t rsp_lsu;

    modport xbar (
        output en,
        output write,
        output row,
        output wdata,
        output lsu_id,
        input  rsp_valid,
        input  rdata,
        input  rsp_lsu
    );

    modport bank (
        input  en,
        input  write,
        input  row,
        input  wdata,
        input  lsu_id,
        output rsp_valid,
        output rdata,
        output rsp_lsu
    );

endinterface

// ==== logic/bg_lsu_crossbar.sv ====
`include "lsu_mem_cfg.svh"

module bg_lsu_crossbar (
    lsu_req_if.xbar              req [`LSU_NUM],
    input  lsu_mem_pkg::bg_sel_t bank_sel [`BG_NUM],
    input  logic                 bank_busy [`BG_NUM],
    bank_if.xbar                 bank [`BG_NUM],
    output logic                 rsp_valid [`LSU_NUM],
    output lsu_mem_pkg::data_t   rsp_rdata [`LSU_NUM]
);

    localparam int BANK_BITS = $bits(lsu_mem_pkg::bg_sel_t);
    localparam int ADDR_W    = $bits(lsu_mem_pkg::word_addr_t);

    logic                    head_write  [`LSU_NUM];
    lsu_mem_pkg::word_addr_t head_addr   [`LSU_NUM];
    lsu_mem_pkg::data_t      head_wdata  [`LSU_NUM];
    logic                    b_rsp_valid [`BG_NUM];
    lsu_mem_pkg::data_t      b_rdata     [`BG_NUM];
    lsu_mem_pkg::bg_sel_t    b_rsp_lsu   [`BG_NUM];

    for (genvar i = 0; i < `LSU_NUM; i++) begin : g_head
        assign head_write[i] = req[i].head_write;
        assign head_addr[i]  = req[i].head_addr;
        assign head_wdata[i] = req[i].head_wdata;
    end

    // LSU to bank, driven by the arbiter's pick
    for (genvar b = 0; b < `BG_NUM; b++) begin : g_bank
        assign bank[b].en     = bank_busy[b];
        assign bank[b].write  = head_write[bank_sel[b]];
        assign bank[b].row    = head_addr[bank_sel[b]][ADDR_W-1:BANK_BITS];
        assign bank[b].wdata  = head_wdata[bank_sel[b]];
        assign bank[b].lsu_id = bank_sel[b];
        assign b_rsp_valid[b] = bank[b].rsp_valid;
        assign b_rdata[b]     = bank[b].rdata;
        assign b_rsp_lsu[b]   = bank[b].rsp_lsu;
    end

    // Bank to LSU, steered by the tag each bank returns
    always_comb begin
        for (int l = 0; l < `LSU_NUM; l++) begin
            rsp_valid[l] = 1'b0;
            rsp_rdata[l] = '0;
            for (int b = 0; b < `BG_NUM; b++) begin
                if (b_rsp_valid[b] && b_rsp_lsu[b] == lsu_mem_pkg::bg_sel_t'(l)) begin
                    rsp_valid[l] = 1'b1;
                    rsp_rdata[l] = b_rdata[b];
                end
            end
        end
    end

    for (genvar l = 0; l < `LSU_NUM; l++) begin : g_rsp_chk
        logic [`BG_NUM-1:0] hit;
        for (genvar b = 0; b < `BG_NUM; b++) begin : g_hit
            assign hit[b] = b_rsp_valid[b] && b_rsp_lsu[b] == lsu_mem_pkg::bg_sel_t'(l);
        end
        always_comb begin
            a_one_bank_per_lsu: assert final ($countones(hit) <= 1);
        end
    end

endmodule

// ==== logic/lsu_mem_pkg.sv ====
`include "lsu_mem_cfg.svh"

package lsu_mem_pkg;

    // One memory word
    typedef logic [`DATA_W-1:0] data_t;

    // Names an LSU or a bank group
    typedef logic [$clog2(`BG_NUM)-1:0] bg_sel_t;

    // Row inside one bank
    typedef logic [$clog2(`BG_DEPTH)-1:0] row_t;

    // Word address, row in the upper bits and bank in the low bits
    typedef logic [$bits(row_t)+$bits(bg_sel_t)-1:0] word_addr_t;

    // Last LSU granted on a bank
    typedef enum bg_sel_t {
        LAST_L0,
        LAST_L1,
        LAST_L2,
        LAST_L3
    } rr_state_e;

endpackage

// ==== logic/lsu_mem_top.sv ====
`include "lsu_mem_cfg.svh"

module lsu_mem_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid [`LSU_NUM],
    input  logic                    req_write [`LSU_NUM],
    input  lsu_mem_pkg::word_addr_t req_addr  [`LSU_NUM],
    input  lsu_mem_pkg::data_t      req_wdata [`LSU_NUM],
    output logic                    credit    [`LSU_NUM],
    output logic                    rsp_valid [`LSU_NUM],
    output lsu_mem_pkg::data_t      rsp_rdata [`LSU_NUM]
);

    lsu_mem_pkg::bg_sel_t bank_sel  [`BG_NUM];
    logic                 bank_busy [`BG_NUM];

    lsu_req_if lsu_req [`LSU_NUM] ();
    bank_if    bank_bus [`BG_NUM] ();

    for (genvar i = 0; i < `LSU_NUM; i++) begin : g_port
        lsu_port u_port (
            .clk       (clk),
            .reset     (reset),
            .req_valid (req_valid[i]),
            .req_write (req_write[i]),
            .req_addr  (req_addr[i]),
            .req_wdata (req_wdata[i]),
            .credit    (credit[i]),
            .req       (lsu_req[i])
        );
    end

    bank_arbiter u_arb (
        .clk       (clk),
        .reset     (reset),
        .req       (lsu_req),
        .bank_sel  (bank_sel),
        .bank_busy (bank_busy)
    );

    bg_lsu_crossbar u_xbar (
        .req       (lsu_req),
        .bank_sel  (bank_sel),
        .bank_busy (bank_busy),
        .bank      (bank_bus),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata)
    );

    for (genvar b = 0; b < `BG_NUM; b++) begin : g_bank
        bank_group u_bank (
            .clk   (clk),
            .reset (reset),
            .bank  (bank_bus[b])
        );
    end

endmodule

// ==== logic/lsu_port.sv ====
`include "lsu_mem_cfg.svh"

module lsu_port (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  lsu_mem_pkg::word_addr_t req_addr,
    input  lsu_mem_pkg::data_t      req_wdata,
    output logic                    credit,
    lsu_req_if.port                 req
);

    localparam int PTR_W = $clog2(`LSU_Q_DEPTH);

    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W:0]          count;
    logic                    pop;
    logic                    q_write [`LSU_Q_DEPTH];
    lsu_mem_pkg::word_addr_t q_addr  [`LSU_Q_DEPTH];
    lsu_mem_pkg::data_t      q_wdata [`LSU_Q_DEPTH];

    // Head leaves in its grant cycle and the credit goes back right away
    assign pop    = req.grant;
    assign credit = pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_write[wr_ptr] <= req_write;
            q_addr[wr_ptr]  <= req_addr;
            q_wdata[wr_ptr] <= req_wdata;
        end
    end

    assign req.head_valid = (count != '0);
    assign req.head_write = q_write[rd_ptr];
    assign req.head_addr  = q_addr[rd_ptr];
    assign req.head_wdata = q_wdata[rd_ptr];

    // Sender must hold a credit, a slot freed this cycle counts
    a_credit_respected: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> (count < `LSU_Q_DEPTH) || pop);

endmodule

// ==== logic/lsu_req_if.sv ====
interface lsu_req_if;

    logic                    head_valid;
    logic                    head_write;
    lsu_mem_pkg::word_addr_t head_addr;
    lsu_mem_pkg::data_t      head_wdata;
    logic                    grant;

    // Queue side
    modport port (
        output head_valid,
        output head_write,
        output head_addr,
        output head_wdata,
        input  grant
    );

    modport arb (
        input  head_valid,
        input  head_addr,
        output grant
    );

    modport xbar (
        input  head_write,
        input  head_addr,
        input  head_wdata
    );

endinterface

// ==== sim/clk_gen.sv ====
module clk_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    localparam time HALF_PERIOD = 10ns;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

// ==== sim/lsu_mem_input.txt ====
// phase lsu write addr wdata expected, all hex, one request per line
// writes carry expected 0, reads carry wdata 0
0 0 1 04 04a55a04 00000000
0 0 1 05 05a55a05 00000000
0 0 1 06 06a55a06 00000000
0 0 1 07 07a55a07 00000000
0 1 1 08 08a55a08 00000000
0 1 1 09 09a55a09 00000000
0 1 1 0a 0aa55a0a 00000000
0 1 1 0b 0ba55a0b 00000000
0 2 1 0c 0ca55a0c 00000000
0 2 1 0d 0da55a0d 00000000
0 2 1 0e 0ea55a0e 00000000
0 2 1 0f 0fa55a0f 00000000
0 3 1 10 10a55a10 00000000
0 3 1 11 11a55a11 00000000
0 3 1 12 12a55a12 00000000
0 3 1 13 13a55a13 00000000
1 0 0 08 00000000 08a55a08
1 1 0 0c 00000000 0ca55a0c
1 2 0 10 00000000 10a55a10
1 3 0 04 00000000 04a55a04
2 1 0 05 00000000 05a55a05
2 1 0 0e 00000000 0ea55a0e
2 1 0 13 00000000 13a55a13
2 1 0 10 00000000 10a55a10
3 0 0 09 00000000 09a55a09
3 1 0 12 00000000 12a55a12
3 2 0 07 00000000 07a55a07
3 3 0 0c 00000000 0ca55a0c

// ==== sim/tb_lsu_mem.sv ====
`include "lsu_mem_cfg.svh"

module tb_lsu_mem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_LINES = 64;
    localparam int FIELDS    = 6;
    localparam int DEPTH     = `LSU_Q_DEPTH;
    localparam int COL_PHASE = 0;
    localparam int COL_LSU   = 1;
    localparam int COL_WRITE = 2;
    localparam int COL_ADDR  = 3;
    localparam int COL_WDATA = 4;
    localparam int COL_EXP   = 5;

    logic                    clk;
    logic                    reset;
    logic                    req_valid [`LSU_NUM];
    logic                    req_write [`LSU_NUM];
    lsu_mem_pkg::word_addr_t req_addr  [`LSU_NUM];
    lsu_mem_pkg::data_t      req_wdata [`LSU_NUM];
    logic                    credit    [`LSU_NUM];
    logic                    rsp_valid [`LSU_NUM];
    lsu_mem_pkg::data_t      rsp_rdata [`LSU_NUM];

    logic [31:0]        stim [MAX_LINES*FIELDS];
    lsu_mem_pkg::data_t exp_q [`LSU_NUM][$];
    int                 credits     [`LSU_NUM];
    int                 outstanding [`LSU_NUM];
    int                 idle        [`LSU_NUM];
    int                 cursor      [`LSU_NUM];
    int                 n_lines;
    int                 max_phase;
    int                 issued_total;
    int                 cycle_count;
    int                 timeout_cycles;
    integer             seed;

    clk_gen u_clk (
        .clk (clk)
    );

    lsu_mem_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .credit    (credit),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] field(input int line, input int col);
        return stim[line*FIELDS + col];
    endfunction

    // Next line of this phase for this LSU, in file order
    function automatic int next_line(input int lsu, input int phase, input int from);
        for (int i = from; i < n_lines; i++) begin
            if (field(i, COL_PHASE) == phase && field(i, COL_LSU) == lsu) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_data(input int lsu, input lsu_mem_pkg::data_t got,
                              input lsu_mem_pkg::data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: rsp_rdata[%0d] = 0x%h, expected 0x%h",
                                     lsu, got, exp));
        end
    endtask

    task automatic check_credit(input int lsu);
        if (outstanding[lsu] < 0) begin
            report_failure($sformatf("LSU %0d returned a credit with no request outstanding",
                                     lsu));
        end else if (credits[lsu] > DEPTH) begin
            report_failure($sformatf("LSU %0d credit counter rose above the queue depth", lsu));
        end
    endtask

    task automatic service_outputs();
        lsu_mem_pkg::data_t exp;
        for (int l = 0; l < `LSU_NUM; l++) begin
            if ($isunknown(credit[l]) || $isunknown(rsp_valid[l])) begin
                report_failure($sformatf("LSU %0d drives an unknown credit or rsp_valid", l));
            end
            if (credit[l]) begin
                credits[l]++;
                outstanding[l]--;
                check_credit(l);
            end
            if (rsp_valid[l]) begin
                if (exp_q[l].size() == 0) begin
                    report_failure($sformatf("LSU %0d got a read response nobody asked for", l));
                end else begin
                    exp = exp_q[l].pop_front();
                    check_data(l, rsp_rdata[l], exp);
                end
            end
        end
    endtask

    task automatic drive_requests(input int phase);
        int idx;
        for (int l = 0; l < `LSU_NUM; l++) begin
            req_valid[l] = 1'b0;
            req_write[l] = 1'b0;
            req_addr[l]  = '0;
            req_wdata[l] = '0;
            idx = next_line(l, phase, cursor[l]);
            if (idle[l] > 0) begin
                idle[l]--;
            end else if (idx >= 0 && credits[l] > 0) begin
                req_valid[l] = 1'b1;
                req_write[l] = (field(idx, COL_WRITE) != 0);
                req_addr[l]  = lsu_mem_pkg::word_addr_t'(field(idx, COL_ADDR));
                req_wdata[l] = field(idx, COL_WDATA);
                if (!req_write[l]) begin
                    exp_q[l].push_back(field(idx, COL_EXP));
                end
                credits[l]--;
                outstanding[l]++;
                issued_total++;
                cursor[l] = idx + 1;
                // Phase 0 runs back to back so the credit counters drain
                if (phase == 0) begin
                    idle[l] = 0;
                end else begin
                    idle[l] = $unsigned($random(seed)) % 3;
                end
            end
        end
    endtask

    // Phase ends once everything is issued, granted and answered
    function automatic bit phase_settled(input int phase);
        for (int l = 0; l < `LSU_NUM; l++) begin
            if (next_line(l, phase, cursor[l]) >= 0 || credits[l] != DEPTH ||
                exp_q[l].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_cycles > 0 && cycle_count > timeout_cycles) begin
            report_failure($sformatf("Run timed out after %0d cycles", cycle_count));
        end
    end

    initial begin
        seed  = 59;
        reset = 1'b1;
        for (int l = 0; l < `LSU_NUM; l++) begin
            req_valid[l]   = 1'b0;
            req_write[l]   = 1'b0;
            req_addr[l]    = '0;
            req_wdata[l]   = '0;
            credits[l]     = DEPTH;
            outstanding[l] = 0;
            idle[l]        = 0;
        end
        for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
            stim[i] = '1;
        end
        $readmemh("sim/lsu_mem_input.txt", stim);
        n_lines   = 0;
        max_phase = 0;
        while (n_lines < MAX_LINES && stim[n_lines*FIELDS] != '1) begin
            if (int'(field(n_lines, COL_PHASE)) > max_phase) begin
                max_phase = int'(field(n_lines, COL_PHASE));
            end
            n_lines++;
        end
        if (n_lines == 0) begin
            report_failure("No stimulus lines could be read from sim/lsu_mem_input.txt");
        end
        timeout_cycles = 30 * n_lines + 200;

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Every LSU starts a phase in the same cycle
        for (int p = 0; p <= max_phase; p++) begin
            for (int l = 0; l < `LSU_NUM; l++) begin
                cursor[l] = 0;
                idle[l]   = 0;
            end
            do begin
                @(negedge clk);
                service_outputs();
                drive_requests(p);
            end while (!phase_settled(p));
        end

        // A few quiet cycles to catch stray credits or responses
        repeat (4) begin
            @(negedge clk);
            service_outputs();
        end

        if (issued_total != n_lines) begin
            report_failure($sformatf("Only %0d of %0d stimulus lines were issued",
                                     issued_total, n_lines));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule
